// File: serialIo.f
serialIoPkg.sv
serialControl.sv
serialTransmitter.sv
serialReceiver.sv
serialIo.sv
serialIoTbClock.sv
serialIoTb.sv

// File: serialIoTb.sv
// Serial I/O loopback testbench
// Table of bus steps with expected values, txd looped back to rxd

module serialIoTb import serialIoPkg::*;
();

  localparam int DataWidth = DefaultDataWidth;
  localparam int BitCycles = 4;

  typedef enum {WriteStep, ReadStep, PollStep} stepKind;

  logic                 Clock;
  logic                 nReset;
  logic                 busSelect;
  logic                 busWrite;
  regAddress            busAddress;
  logic [DataWidth-1:0] busWriteData;
  logic [DataWidth-1:0] busReadData;
  logic                 nIrq;
  logic                 txd;
  logic                 tableReady;

  // Step table, one entry per row in each queue
  string                stepNames[$];
  stepKind              stepKinds[$];
  regAddress            stepAddresses[$];
  logic [DataWidth-1:0] stepValues[$];
  int                   stepPollBits[$];
  logic                 stepIrqNs[$];

  serialIoTbClock u_serialIoTbClock (
    .Clock  (Clock),
    .nReset (nReset)
  );

  // Loopback, txd feeds rxd
  serialIo #(
    .DataWidth    (DataWidth),
    .BitCycles    (BitCycles)
  ) u_serialIo (
    .Clock        (Clock),
    .nReset       (nReset),
    .busSelect    (busSelect),
    .busWrite     (busWrite),
    .busAddress   (busAddress),
    .busWriteData (busWriteData),
    .busReadData  (busReadData),
    .nIrq         (nIrq),
    .rxd          (txd),
    .txd          (txd)
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Status word from flags and masks, Irq when any masked flag is set
  function automatic logic [DataWidth-1:0] expectedStatus(input logic txFree, input logic rxFull,
                                                          input logic txMask, input logic rxMask);
    logic [DataWidth-1:0] s;
    s                  = '0;
    s[StatusTxReqBit]  = txFree && txMask;
    s[StatusRxReqBit]  = rxFull && rxMask;
    s[StatusIrqBit]    = s[StatusTxReqBit] || s[StatusRxReqBit];
    s[StatusTxMaskBit] = txMask;
    s[StatusRxMaskBit] = rxMask;
    s[StatusTxeBit]    = !txFree;
    s[StatusRxfBit]    = !rxFull;
    return s;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Error %s expected %h actual %h", name, expected, actual);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  // One-cycle bus write, ends at the falling edge after the access
  task automatic busWriteCycle(input regAddress address, input logic [DataWidth-1:0] data);
    @(posedge Clock);
    busSelect    <= 1'b1;
    busWrite     <= 1'b1;
    busAddress   <= address;
    busWriteData <= data;
    @(posedge Clock);
    busSelect    <= 1'b0;
    busWrite     <= 1'b0;
    @(negedge Clock);
  endtask

  // Read data is registered, sampled mid-cycle after the access edge
  task automatic busReadCycle(input regAddress address, output logic [DataWidth-1:0] data);
    @(posedge Clock);
    busSelect  <= 1'b1;
    busWrite   <= 1'b0;
    busAddress <= address;
    @(posedge Clock);
    busSelect  <= 1'b0;
    @(negedge Clock);
    data = busReadData;
  endtask

  // Status reads until the chosen bit reaches the level
  task automatic pollStatus(input int bitPos, input logic level);
    logic [DataWidth-1:0] status;
    do
    begin
      busReadCycle(ControlReg, status);
    end
    while (status[bitPos] !== level);
  endtask

  task automatic addStep(input string name, input stepKind kind, input regAddress address,
                         input logic [DataWidth-1:0] value, input int pollBit, input logic irqN);
    stepNames.push_back(name);
    stepKinds.push_back(kind);
    stepAddresses.push_back(address);
    stepValues.push_back(value);
    stepPollBits.push_back(pollBit);
    stepIrqNs.push_back(irqN);
  endtask

  ////////////////////
  // Step table
  ////////////////////

  task automatic buildTable();
    logic [31:0]          seed;
    logic [DataWidth-1:0] words [6];
    seed = 32'h3785_23d7;
    for (int k = 0; k < 6; k++)
    begin
      seed     = xorshift(seed);
      words[k] = seed[DataWidth-1:0];
    end
    // Reset state and masks
    addStep("reset status", ReadStep, ControlReg, expectedStatus(1'b1, 1'b0, 1'b0, 1'b0), 0, 1'b1);
    addStep("set masks", WriteStep, ControlReg, 'h3, 0, 1'b0);
    addStep("masked status", ReadStep, ControlReg, expectedStatus(1'b1, 1'b0, 1'b1, 1'b1), 0, 1'b0);
    addStep("clear masks", WriteStep, ControlReg, 'h0, 0, 1'b1);
    // Single words through the loop
    for (int k = 0; k < 3; k++)
    begin
      addStep($sformatf("write word %0d", k), WriteStep, DataReg, words[k], 0, 1'b1);
      if (k == 0)
        addStep("tx busy", ReadStep, ControlReg, expectedStatus(1'b0, 1'b0, 1'b0, 1'b0), 0, 1'b1);
      addStep($sformatf("tx free %0d", k), PollStep, ControlReg, 'h0, StatusTxeBit, 1'b1);
      addStep($sformatf("rx full %0d", k), PollStep, ControlReg, 'h0, StatusRxfBit, 1'b1);
      addStep($sformatf("read word %0d", k), ReadStep, DataReg, words[k], 0, 1'b1);
      addStep($sformatf("status %0d", k), ReadStep, ControlReg,
              expectedStatus(1'b1, 1'b0, 1'b0, 1'b0), 0, 1'b1);
    end
    // Receive interrupt
    addStep("set rx mask", WriteStep, ControlReg, 'h1, 0, 1'b1);
    addStep("write word 3", WriteStep, DataReg, words[3], 0, 1'b1);
    addStep("rx full 3", PollStep, ControlReg, 'h0, StatusRxfBit, 1'b0);
    addStep("tx free 3", PollStep, ControlReg, 'h0, StatusTxeBit, 1'b0);
    addStep("rx irq", ReadStep, ControlReg, expectedStatus(1'b1, 1'b1, 1'b0, 1'b1), 0, 1'b0);
    addStep("read word 3", ReadStep, DataReg, words[3], 0, 1'b1);
    addStep("rx irq clear", ReadStep, ControlReg, expectedStatus(1'b1, 1'b0, 1'b0, 1'b1), 0, 1'b1);
    // Two words back to back, second held for a credit
    addStep("clear rx mask", WriteStep, ControlReg, 'h0, 0, 1'b1);
    addStep("write word 4", WriteStep, DataReg, words[4], 0, 1'b1);
    addStep("write word 5", WriteStep, DataReg, words[5], 0, 1'b1);
    addStep("second waits", ReadStep, ControlReg, expectedStatus(1'b0, 1'b0, 1'b0, 1'b0), 0, 1'b1);
    addStep("tx free 5", PollStep, ControlReg, 'h0, StatusTxeBit, 1'b1);
    addStep("rx full 4", PollStep, ControlReg, 'h0, StatusRxfBit, 1'b1);
    addStep("read word 4", ReadStep, DataReg, words[4], 0, 1'b1);
    addStep("rx full 5", PollStep, ControlReg, 'h0, StatusRxfBit, 1'b1);
    addStep("read word 5", ReadStep, DataReg, words[5], 0, 1'b1);
    addStep("final status", ReadStep, ControlReg, expectedStatus(1'b1, 1'b0, 1'b0, 1'b0), 0, 1'b1);
  endtask

  ////////////////////
  // Run
  ////////////////////

  initial
  begin
    logic [DataWidth-1:0] readValue;
    busSelect    = 1'b0;
    busWrite     = 1'b0;
    busAddress   = DataReg;
    busWriteData = '0;
    tableReady   = 1'b0;
    buildTable();
    tableReady   = 1'b1;
    wait (nReset === 1'b1);
    // Let the first transmit credit land
    repeat (4) @(posedge Clock);
    // Line idles high out of reset
    checkValue("idle line", 1'b1, txd);
    for (int i = 0; i < stepNames.size(); i++)
    begin
      case (stepKinds[i])
        WriteStep:
          busWriteCycle(stepAddresses[i], stepValues[i]);
        ReadStep:
        begin
          busReadCycle(stepAddresses[i], readValue);
          checkValue(stepNames[i], stepValues[i], readValue);
        end
        default:
          pollStatus(stepPollBits[i], stepValues[i][0]);
      endcase
      // nIrq checked mid-cycle after every step
      checkValue({stepNames[i], " nIrq"}, stepIrqNs[i], nIrq);
    end
    // Back to idle after the last stop bit
    checkValue("idle line at end", 1'b1, txd);
    $display("Regression passed");
    $finish;
  end

  // Watchdog sized from the table length and the word time
  initial
  begin
    int limit;
    wait (tableReady === 1'b1);
    limit = stepNames.size() * (DataWidth + 4) * BitCycles * 3;
    repeat (limit) @(posedge Clock);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Regression failed");
    $fatal(1);
  end

endmodule

// File: serialIoTbClock.sv
// Serial I/O testbench clock and reset
// Clock period 4, reset held low for the first 3 cycles

module serialIoTbClock
(
  output logic Clock,
  output logic nReset
);

  initial
  begin
    Clock  = 1'b0;
    nReset = 1'b0;
    // Release on a rising edge after 3 cycles
    repeat (3) @(posedge Clock);
    nReset <= 1'b1;
  end

  always #2 Clock = ~Clock;

endmodule

// File: serialIo.sv
// Serial I/O peripheral top level
// Register block with transmitter and receiver on txd and rxd

module serialIo import serialIoPkg::*;
#(
  parameter int DataWidth = DefaultDataWidth,
  parameter int BitCycles = DefaultBitCycles
)
(
  input  logic                 Clock,
  input  logic                 nReset,
  input  logic                 busSelect,
  input  logic                 busWrite,
  input  regAddress            busAddress,
  input  logic [DataWidth-1:0] busWriteData,
  output logic [DataWidth-1:0] busReadData,
  output logic                 nIrq,
  input  logic                 rxd,
  output logic                 txd
);

  // Transmit path
  logic                 txCredit;
  logic                 txLoad;
  logic [DataWidth-1:0] txWord;

  // Receive path
  logic                 rxCredit;
  logic                 rxDeliver;
  logic [DataWidth-1:0] rxWord;

  serialControl #(
    .DataWidth    (DataWidth)
  ) u_serialControl (
    .Clock        (Clock),
    .nReset       (nReset),
    .busSelect    (busSelect),
    .busWrite     (busWrite),
    .busAddress   (busAddress),
    .busWriteData (busWriteData),
    .busReadData  (busReadData),
    .nIrq         (nIrq),
    .txCredit     (txCredit),
    .txLoad       (txLoad),
    .txWord       (txWord),
    .rxDeliver    (rxDeliver),
    .rxWord       (rxWord),
    .rxCredit     (rxCredit)
  );

  serialTransmitter #(
    .DataWidth (DataWidth),
    .BitCycles (BitCycles)
  ) u_serialTransmitter (
    .Clock     (Clock),
    .nReset    (nReset),
    .txLoad    (txLoad),
    .txWord    (txWord),
    .txd       (txd),
    .txCredit  (txCredit)
  );

  serialReceiver #(
    .DataWidth (DataWidth),
    .BitCycles (BitCycles)
  ) u_serialReceiver (
    .Clock     (Clock),
    .nReset    (nReset),
    .rxd       (rxd),
    .rxCredit  (rxCredit),
    .rxDeliver (rxDeliver),
    .rxWord    (rxWord)
  );

endmodule

// File: serialReceiver.sv
// Serial receiver
// Finds the start bit, samples each bit at its middle, delivers the word against a credit

module serialReceiver import serialIoPkg::*;
#(
  parameter int DataWidth = DefaultDataWidth,
  parameter int BitCycles = DefaultBitCycles
)
(
  input  logic                 Clock,
  input  logic                 nReset,
  input  logic                 rxd,
  input  logic                 rxCredit,
  output logic                 rxDeliver,
  output logic [DataWidth-1:0] rxWord
);

  localparam int CountWidth = (BitCycles > 1) ? $clog2(BitCycles) : 1;
  localparam int IndexWidth = (DataWidth > 1) ? $clog2(DataWidth) : 1;
  // Middle of the start bit, counted from the detected edge
  localparam int HalfCount  = (BitCycles > 1) ? BitCycles / 2 - 1 : 0;

  serialState            state;
  logic [CountWidth-1:0] bitCount;
  logic [IndexWidth-1:0] bitIndex;
  logic [DataWidth-1:0]  shiftReg;
  logic [1:0]            rxSync;
  logic                  rxPrev;
  logic                  fallingEdge;
  logic                  bitDone;
  logic                  wordReady;
  logic                  creditHeld;

  // Two-stage synchronizer plus one stage for edge detect
  always_ff @(posedge Clock or negedge nReset)
    if (!nReset)
    begin
      rxSync <= 2'b11;
      rxPrev <= 1'b1;
    end
    else
    begin
      rxSync <= {rxSync[0], rxd};
      rxPrev <= rxSync[1];
    end

  assign fallingEdge = rxPrev && !rxSync[1];
  // From mid-start on, each full bit period lands on the next bit middle
  assign bitDone     = (bitCount == CountWidth'(BitCycles - 1));
  // Word out only while a credit is held
  assign rxDeliver   = (state == Stop) && wordReady && creditHeld;
  assign rxWord      = shiftReg;

  always_ff @(posedge Clock or negedge nReset)
    if (!nReset)
    begin
      state      <= Idle;
      bitCount   <= '0;
      bitIndex   <= '0;
      wordReady  <= 1'b0;
      creditHeld <= 1'b0;
    end
    else
    begin
      // One-bit credit counter
      if (rxCredit)
        creditHeld <= 1'b1;
      else if (rxDeliver)
        creditHeld <= 1'b0;
      unique case (state)
        Idle:
        begin
          bitCount <= '0;
          if (fallingEdge)
            state <= Start;
        end
        Start:
          if (bitCount == CountWidth'(HalfCount))
          begin
            bitCount <= '0;
            bitIndex <= '0;
            // Glitch shorter than half a bit goes back to Idle
            state    <= rxSync[1] ? Idle : Data;
          end
          else
            bitCount <= bitCount + 1'b1;
        Data:
          if (bitDone)
          begin
            bitCount <= '0;
            if (bitIndex == IndexWidth'(DataWidth - 1))
              state <= Stop;
            else
              bitIndex <= bitIndex + 1'b1;
          end
          else
            bitCount <= bitCount + 1'b1;
        Stop:
          // Complete at mid stop bit, then hold the word for a credit
          if (!wordReady)
          begin
            bitCount <= bitDone ? '0 : bitCount + 1'b1;
            if (bitDone)
              wordReady <= 1'b1;
          end
          else if (rxDeliver)
          begin
            wordReady <= 1'b0;
            state     <= Idle;
          end
      endcase
    end

  // Data bits enter from the top, LSB arrives first
  always_ff @(posedge Clock)
    if ((state == Data) && bitDone)
      shiftReg <= {rxSync[1], shiftReg[DataWidth-1:1]};

endmodule

// File: serialTransmitter.sv
// Serial transmitter
// Takes one word per credit and shifts it out on txd, start bit, LSB first, stop bit

module serialTransmitter import serialIoPkg::*;
#(
  parameter int DataWidth = DefaultDataWidth,
  parameter int BitCycles = DefaultBitCycles
)
(
  input  logic                 Clock,
  input  logic                 nReset,
  input  logic                 txLoad,
  input  logic [DataWidth-1:0] txWord,
  output logic                 txd,
  output logic                 txCredit
);

  localparam int CountWidth = (BitCycles > 1) ? $clog2(BitCycles) : 1;
  localparam int IndexWidth = (DataWidth > 1) ? $clog2(DataWidth) : 1;

  serialState            state;
  logic [CountWidth-1:0] bitCount;
  logic [IndexWidth-1:0] bitIndex;
  logic [DataWidth-1:0]  shiftReg;
  logic                  bitDone;
  logic                  started;

  // Last clock of the current bit
  assign bitDone = (bitCount == CountWidth'(BitCycles - 1));

  always_ff @(posedge Clock or negedge nReset)
    if (!nReset)
    begin
      state    <= Idle;
      bitCount <= '0;
      bitIndex <= '0;
      started  <= 1'b0;
      txCredit <= 1'b0;
    end
    else
    begin
      started  <= 1'b1;
      // Credit once after reset and on every return to Idle
      txCredit <= !started || ((state == Stop) && bitDone);
      if (state == Idle)
        bitCount <= '0;
      else
        bitCount <= bitDone ? '0 : bitCount + 1'b1;
      unique case (state)
        Idle:
          if (txLoad)
            state <= Start;
        Start:
          if (bitDone)
          begin
            state    <= Data;
            bitIndex <= '0;
          end
        Data:
          if (bitDone)
          begin
            if (bitIndex == IndexWidth'(DataWidth - 1))
              state <= Stop;
            else
              bitIndex <= bitIndex + 1'b1;
          end
        Stop:
          if (bitDone)
            state <= Idle;
      endcase
    end

  // Shifter, LSB goes out first
  always_ff @(posedge Clock)
    if ((state == Idle) && txLoad)
      shiftReg <= txWord;
    else if ((state == Data) && bitDone)
      shiftReg <= shiftReg >> 1;

  // Line level per phase, idle high
  always_comb
    unique case (state)
      Start:   txd = 1'b0;
      Data:    txd = shiftReg[0];
      default: txd = 1'b1;
    endcase

endmodule

// File: serialControl.sv
// Serial I/O register block
// Bus decode, status and interrupts, credit bookkeeping toward transmitter and receiver

module serialControl import serialIoPkg::*;
#(
  parameter int DataWidth = DefaultDataWidth
)
(
  input  logic                 Clock,
  input  logic                 nReset,
  input  logic                 busSelect,
  input  logic                 busWrite,
  input  regAddress            busAddress,
  input  logic [DataWidth-1:0] busWriteData,
  output logic [DataWidth-1:0] busReadData,
  output logic                 nIrq,
  input  logic                 txCredit,
  output logic                 txLoad,
  output logic [DataWidth-1:0] txWord,
  input  logic                 rxDeliver,
  input  logic [DataWidth-1:0] rxWord,
  output logic                 rxCredit
);

  logic [DataWidth-1:0] writeData;
  logic [DataWidth-1:0] readData;
  logic [DataWidth-1:0] status;
  logic                 dataWrite;
  logic                 controlWrite;
  logic                 dataRead;
  logic                 txPending;
  logic                 txCreditHeld;
  logic                 txe;
  logic                 rxf;
  logic                 rxStarted;
  logic                 txIntMask;
  logic                 rxIntMask;
  logic                 txIntReq;
  logic                 rxIntReq;
  logic                 irq;

  // Bus cycle decode, one cycle per access
  assign dataWrite    = busSelect && busWrite && (busAddress == DataReg);
  assign controlWrite = busSelect && busWrite && (busAddress == ControlReg);
  assign dataRead     = busSelect && !busWrite && (busAddress == DataReg);

  ////////////////////
  // Transmit side
  ////////////////////

  // Word waits in writeData until a credit is held
  assign txLoad = txCreditHeld && txPending;
  assign txWord = writeData;
  // Free for the next word only once the transmitter can take it
  assign txe    = txCreditHeld && !txPending;

  always_ff @(posedge Clock or negedge nReset)
    if (!nReset)
    begin
      txCreditHeld <= 1'b0;
      txPending    <= 1'b0;
    end
    else
    begin
      // One-bit credit counter
      if (txCredit)
        txCreditHeld <= 1'b1;
      else if (txLoad)
        txCreditHeld <= 1'b0;
      // A new write wins over the load that empties the register
      if (dataWrite)
        txPending <= 1'b1;
      else if (txLoad)
        txPending <= 1'b0;
    end

  always_ff @(posedge Clock)
    if (dataWrite)
      writeData <= busWriteData;

  ////////////////////
  // Receive side
  ////////////////////

  always_ff @(posedge Clock or negedge nReset)
    if (!nReset)
    begin
      rxStarted <= 1'b0;
      rxCredit  <= 1'b0;
      rxf       <= 1'b0;
    end
    else
    begin
      rxStarted <= 1'b1;
      // First credit after reset, then one per consumed word
      rxCredit  <= !rxStarted || (dataRead && rxf);
      if (rxDeliver)
        rxf <= 1'b1;
      else if (dataRead)
        rxf <= 1'b0;
    end

  always_ff @(posedge Clock)
    if (rxDeliver)
      readData <= rxWord;

  ////////////////////
  // Masks and status
  ////////////////////

  always_ff @(posedge Clock or negedge nReset)
    if (!nReset)
    begin
      txIntMask <= 1'b0;
      rxIntMask <= 1'b0;
    end
    else if (controlWrite)
    begin
      txIntMask <= busWriteData[1];
      rxIntMask <= busWriteData[0];
    end

  assign txIntReq = txe && txIntMask;
  assign rxIntReq = rxf && rxIntMask;
  assign irq      = txIntReq || rxIntReq;
  assign nIrq     = !irq;

  always_comb
  begin
    status                  = '0;
    status[StatusIrqBit]    = irq;
    status[StatusTxReqBit]  = txIntReq;
    status[StatusRxReqBit]  = rxIntReq;
    status[StatusTxMaskBit] = txIntMask;
    status[StatusRxMaskBit] = rxIntMask;
    status[StatusTxeBit]    = !txe;
    status[StatusRxfBit]    = !rxf;
  end

  // Read data registered, zero when no read was made
  always_ff @(posedge Clock or negedge nReset)
    if (!nReset)
      busReadData <= '0;
    else if (busSelect && !busWrite)
      busReadData <= (busAddress == DataReg) ? readData : status;
    else
      busReadData <= '0;

endmodule

// File: serialIoPkg.sv
// Serial I/O shared definitions
// Line phases, register map and status bit positions

package serialIoPkg;

  ////////////////////
  // Geometry
  ////////////////////

  // Word size, at least 16 so the status layout fits
  localparam int DefaultDataWidth = 16;

  // Clocks per bit on the serial line
  localparam int DefaultBitCycles = 8;

  ////////////////////
  // Line phases
  ////////////////////

  // Shared by transmitter and receiver
  typedef enum logic [1:0] {
    Idle,
    Start,
    Data,
    Stop
  } serialState;

  ////////////////////
  // Register map
  ////////////////////

  // Read data / write data at 0, status / control at 1
  typedef enum logic {
    DataReg    = 1'b0,
    ControlReg = 1'b1
  } regAddress;

  // Status bit positions
  localparam int StatusIrqBit    = 15;
  localparam int StatusTxReqBit  = 5;
  localparam int StatusRxReqBit  = 4;
  localparam int StatusTxMaskBit = 3;
  localparam int StatusRxMaskBit = 2;
  localparam int StatusTxeBit    = 1;
  localparam int StatusRxfBit    = 0;

endpackage
